/* files.f */
rtl/spi_defs_pkg.sv
rtl/bus_defs_pkg.sv
rtl/spi_target.sv
rtl/spi_slave.sv
rtl/reg_bank.sv
rtl/spi_bridge_top.sv
bench/tb_spi_bridge.sv

/* Makefile */
# Verilator flow for the SPI bridge testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_spi_bridge
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 32'h075547b0
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		"-Gseed_init=$(SEED)" -f $(FILELIST)

# the simulator exit code is ignored, the log decides
run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "All tests passed!" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/spi_cases.txt */
// op adr frames | d0 d1 d2 d3 mosi data | e0 e1 e2 e3 miso after header (hex)
// op 1 writes, op 0 reads; columns past the frame count are ignored
0 00 2  00 00 00 00  00 00 00 00   // registers start at zero
0 0F 1  00 00 00 00  00 00 00 00
0 09 1  00 00 00 00  00 00 00 00
1 03 1  5A 00 00 00  00 00 00 00   // single byte write
0 03 1  00 00 00 00  5A 00 00 00
0 13 1  00 00 00 00  5A 00 00 00   // alias of 03
1 07 3  11 22 C3 00  00 00 00 00   // last byte stays
0 07 4  00 00 00 00  C3 C3 C3 C3
1 00 1  81 00 00 00  00 00 00 00
1 0F 2  7E E5 00 00  00 00 00 00
1 28 1  96 00 00 00  00 00 00 00   // lands in 08
0 00 1  00 00 00 00  81 00 00 00
0 0F 2  00 00 00 00  E5 E5 00 00
0 08 1  00 00 00 00  96 00 00 00
0 03 1  00 00 00 00  5A 00 00 00   // untouched by later writes
0 47 3  00 00 00 00  C3 C3 C3 00   // alias of 07

/* bench/tb_spi_bridge.sv */
`timescale 1ns/1ps

module tb_spi_bridge #(
   parameter int unsigned seed_init = 32'h075547b0   // gap generator seed
);

   // -------------------------------------------------------------------------
   //  timing and case table layout
   // -------------------------------------------------------------------------
   localparam int clk_period   = 10;                  // ns
   localparam int reset_cycles = 8;
   localparam int half_sck     = 8;                   // clocks per sck phase so sck is clk/16
   localparam int idle_cycles  = 24;                  // ssel high between transactions
   localparam int gap_max      = 16;                  // extra sck low time before a frame
   localparam int max_cases    = 32;
   localparam int case_fields  = 11;                  // op, adr, n, d0..d3, e0..e3
   localparam int max_frames   = 5;                   // command plus four data frames
   localparam int case_budget  = max_frames * 8 * 2 * half_sck + max_frames * gap_max + 64;

   logic clk = 1'b0;
   logic rst, sck, ssel, mosi;
   logic miso, active, overflow, underrun;

   logic [7:0] cases_mem [max_cases * case_fields];
   logic [7:0] model [16];                            // what the bank should hold
   int         num_cases;
   integer     seed;
   longint     limit_ns = 0;                          // watchdog arms once nonzero

   always #(clk_period / 2) clk = ~clk;

   spi_bridge_top uut (
      .clk_i      (clk),
      .rst_i      (rst),
      .sck_i      (sck),
      .ssel_i     (ssel),
      .mosi_i     (mosi),
      .miso_o     (miso),
      .active_o   (active),
      .overflow_o (overflow),
      .underrun_o (underrun)
   );

   // -------------------------------------------------------------------------
   //  failure reporting
   // -------------------------------------------------------------------------
   task automatic report_mismatch(input string sig, input logic [7:0] expected,
                                  input logic [7:0] actual);
      $display("[FAIL] t=%0t ns %s expected %02h got %02h", $time, sig, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at the first mismatch");
   endtask

   task automatic give_up(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "run aborted");
   endtask

   // -------------------------------------------------------------------------
   //  spi master, mode 0, msb first
   // -------------------------------------------------------------------------
   // enters and leaves on a rising clk edge with sck low
   task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
      for (int b = 7; b >= 0; b--) begin
         mosi <= tx[b];                               // set up while sck is low
         repeat (half_sck - 1) @(posedge clk);
         @(negedge clk);
         rx[b] = miso;                                // settled long before the rise
         @(posedge clk);
         sck <= 1'b1;                                 // target samples mosi here
         repeat (half_sck) @(posedge clk);
         sck <= 1'b0;                                 // target moves miso
      end
   endtask

   task automatic load_cases();
      num_cases = 0;
      for (int i = 0; i < max_cases * case_fields; i++)
         cases_mem[i] = 8'hFF;                        // op of ff ends the table
      $readmemh("bench/spi_cases.txt", cases_mem);
      while (num_cases < max_cases && cases_mem[num_cases * case_fields] != 8'hFF)
         num_cases++;
   endtask

   // one full transaction with the command frame and the listed data frames
   task automatic run_case(input int idx);
      int         base;
      int         frames;
      int         gap;
      logic       wr;
      logic [6:0] adr;
      logic [7:0] rx;
      logic [7:0] exp_file;
      logic [7:0] exp_model;
      base   = idx * case_fields;
      wr     = cases_mem[base][0];
      adr    = cases_mem[base + 1][6:0];
      frames = int'(cases_mem[base + 2]);
      if (frames < 1 || frames > 4)
         give_up($sformatf("case %0d asks for %0d data frames, 1 to 4 are allowed",
                           idx, frames));
      $display("case %0d: %s adr %02h, %0d data frames", idx, wr ? "write" : "read",
               adr, frames);

      ssel <= 1'b0;
      repeat (half_sck) @(posedge clk);               // header reaches miso first
      shift_byte({wr, adr}, rx);
      assert (rx == spi_defs_pkg::header_byte)
         else report_mismatch($sformatf("miso_o header (case %0d)", idx),
                              spi_defs_pkg::header_byte, rx);

      // at the midpoint the transaction is open with no errors so far
      @(negedge clk);
      assert (active == 1'b1)
         else report_mismatch("active_o mid transaction", 8'h01, 8'(active));
      assert (overflow == 1'b0) else report_mismatch("overflow_o", 8'h00, 8'(overflow));
      assert (underrun == 1'b0) else report_mismatch("underrun_o", 8'h00, 8'(underrun));
      @(posedge clk);

      for (int f = 0; f < frames; f++) begin
         gap = int'($unsigned($random(seed)) % gap_max);
         repeat (gap) @(posedge clk);
         shift_byte(cases_mem[base + 3 + f], rx);
         exp_file  = cases_mem[base + 7 + f];
         exp_model = wr ? 8'h00 : model[adr[3:0]];    // writes see the idle word
         assert (exp_file == exp_model)
            else give_up($sformatf("case %0d lists %02h for frame %0d, the model says %02h",
                                   idx, exp_file, f + 1, exp_model));
         assert (rx == exp_model)
            else report_mismatch($sformatf("miso_o (case %0d frame %0d)", idx, f + 1),
                                 exp_model, rx);
         if (wr)
            model[adr[3:0]] = cases_mem[base + 3 + f];   // upper bits alias
      end

      repeat (half_sck) @(posedge clk);
      ssel <= 1'b1;
      repeat (idle_cycles) @(posedge clk);

      // flags are sticky so the idle check covers the whole transaction
      @(negedge clk);
      assert (active == 1'b0) else report_mismatch("active_o idle", 8'h00, 8'(active));
      assert (miso == 1'b0) else report_mismatch("miso_o idle", 8'h00, 8'(miso));
      assert (overflow == 1'b0) else report_mismatch("overflow_o", 8'h00, 8'(overflow));
      assert (underrun == 1'b0) else report_mismatch("underrun_o", 8'h00, 8'(underrun));
      @(posedge clk);
   endtask

   // -------------------------------------------------------------------------
   //  main sequence
   // -------------------------------------------------------------------------
   initial begin : main
      rst        = 1'b1;
      sck        = 1'b0;
      ssel       = 1'b1;
      mosi       = 1'b0;
      seed       = seed_init;
      for (int i = 0; i < 16; i++)
         model[i] = 8'h00;                            // reset clears the bank
      load_cases();
      if (num_cases == 0)
         give_up("case file bench/spi_cases.txt is missing or holds no cases");
      limit_ns = longint'(reset_cycles + 8 + num_cases * case_budget) * clk_period;

      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      repeat (4) @(posedge clk);

      for (int i = 0; i < num_cases; i++)
         run_case(i);

      $display("All tests passed!");
      $finish;
   end

   // every case fits in case_budget clocks
   initial begin : watchdog
      wait (limit_ns != 0);
      #(limit_ns);
      give_up($sformatf("timeout, the run did not finish within %0d ns", limit_ns));
   end

endmodule

/* rtl/spi_bridge_top.sv */
`timescale 1ns/1ps

// spi bridge in front of the register bank
module spi_bridge_top (
   input  logic clk_i,
   input  logic rst_i,
   input  logic sck_i,
   input  logic ssel_i,                        // active low
   input  logic mosi_i,
   output logic miso_o,
   output logic active_o,
   output logic overflow_o,
   output logic underrun_o
);

   // classic bus between bridge and bank
   logic                              cyc, stb, we, ack;
   logic [bus_defs_pkg::adr_width-1:0] adr;
   logic [bus_defs_pkg::dat_width-1:0] wdat;   // bridge to bank
   logic [bus_defs_pkg::dat_width-1:0] rdat;   // bank to bridge

   spi_slave bridge0 (
      .clk_i (clk_i),  .rst_i (rst_i),
      .cyc_o (cyc),    .stb_o (stb),    .we_o (we),    .ack_i (ack),
      .adr_o (adr),    .dat_i (rdat),   .dat_o (wdat),
      .active_o (active_o), .overflow_o (overflow_o), .underrun_o (underrun_o),
      .sck_i (sck_i),  .ssel_i (ssel_i), .mosi_i (mosi_i), .miso_o (miso_o)
   );

   reg_bank bank0 (
      .clk_i (clk_i),  .rst_i (rst_i),
      .cyc_i (cyc),    .stb_i (stb),    .we_i (we),
      .adr_i (adr),    .dat_i (wdat),
      .ack_o (ack),    .dat_o (rdat)
   );

endmodule

/* rtl/reg_bank.sv */
`timescale 1ns/1ps

// sixteen byte registers on a classic bus that acks one cycle after stb
module reg_bank (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  logic                              cyc_i,
   input  logic                              stb_i,
   input  logic                              we_i,
   input  logic [bus_defs_pkg::adr_width-1:0] adr_i,
   input  logic [bus_defs_pkg::dat_width-1:0] dat_i,
   output logic                              ack_o,
   output logic [bus_defs_pkg::dat_width-1:0] dat_o
);

   logic [bus_defs_pkg::dat_width-1:0]     regs [bus_defs_pkg::reg_count];
   logic [bus_defs_pkg::reg_sel_width-1:0] sel;     // upper address bits alias
   logic                                   req;

   assign sel = adr_i[bus_defs_pkg::reg_sel_width-1:0];
   assign req = cyc_i & stb_i & ~ack_o;             // new request and not the one just acked

   // --------------------------------------------------------------------------
   //  acknowledge
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= req;                              // single cycle
   end

   // --------------------------------------------------------------------------
   //  register file
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < bus_defs_pkg::reg_count; i++)
            regs[i] <= '0;
      end else if (req && we_i) begin
         regs[sel] <= dat_i;
      end
   end

   // read data comes out together with ack
   always_ff @(posedge clk_i) begin
      if (req)
         dat_o <= regs[sel];
   end

   // the bridge must drop stb for a cycle after each ack
   a_stb_drop : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |=> !stb_i);

endmodule

/* rtl/spi_slave.sv */
`timescale 1ns/1ps

// spi to classic bus bridge
// the first byte is r/w flag plus address and every later byte is one bus
// cycle at that address
module spi_slave (
   input  logic                              clk_i,
   input  logic                              rst_i,
   // classic bus master
   output logic                              cyc_o,
   output logic                              stb_o,
   output logic                              we_o,
   input  logic                              ack_i,
   output logic [bus_defs_pkg::adr_width-1:0] adr_o,
   input  logic [bus_defs_pkg::dat_width-1:0] dat_i,
   output logic [bus_defs_pkg::dat_width-1:0] dat_o,
   // diagnostics
   output logic                              active_o,
   output logic                              overflow_o,
   output logic                              underrun_o,
   // spi pins
   input  logic                              sck_i,
   input  logic                              ssel_i,
   input  logic                              mosi_i,
   output logic                              miso_o
);

   // --------------------------------------------------------------------------
   //  target side
   // --------------------------------------------------------------------------
   logic                                 t_cyc, t_stb, t_first;
   logic [spi_defs_pkg::frame_width-1:0] t_drx;
   logic [spi_defs_pkg::frame_width-1:0] t_dtx;   // prefetched read data
   logic                                 t_busy;
   spi_defs_pkg::cmd_byte_u              cmd_word;
   logic [1:0]                           state;

   assign cmd_word.raw = t_drx;
   assign active_o     = t_cyc;
   assign t_busy       = (state == spi_defs_pkg::st_transfer);   // bus cycle open

   // --------------------------------------------------------------------------
   //  bridge fsm
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= spi_defs_pkg::st_idle;
         cyc_o <= 1'b0;
         stb_o <= 1'b0;
         we_o  <= 1'b0;
      end else begin
         case (state)
            spi_defs_pkg::st_idle:
               if (t_cyc)
                  state <= spi_defs_pkg::st_address;

            spi_defs_pkg::st_address:
               if (!t_cyc) begin
                  state <= spi_defs_pkg::st_idle;          // aborted before command
               end else if (t_stb && t_first) begin
                  we_o <= cmd_word.fields.wr;
                  if (cmd_word.fields.wr) begin
                     state <= spi_defs_pkg::st_busy;       // wait for write data
                  end else begin
                     state <= spi_defs_pkg::st_transfer;   // prefetch for frame 2
                     cyc_o <= 1'b1;
                     stb_o <= 1'b1;
                  end
               end

            spi_defs_pkg::st_busy:
               if (!t_cyc) begin
                  state <= spi_defs_pkg::st_idle;
               end else if (t_stb) begin
                  // write pushes the byte and read fetches for the next frame
                  state <= spi_defs_pkg::st_transfer;
                  cyc_o <= 1'b1;
                  stb_o <= 1'b1;
               end

            spi_defs_pkg::st_transfer:
               if (ack_i) begin
                  cyc_o <= 1'b0;                           // at least one idle cycle
                  stb_o <= 1'b0;
                  state <= t_cyc ? spi_defs_pkg::st_busy : spi_defs_pkg::st_idle;
               end

            default:
               state <= spi_defs_pkg::st_idle;
         endcase
      end
   end

   // address is held for the whole transaction without auto-increment
   always_ff @(posedge clk_i) begin
      if (state == spi_defs_pkg::st_address && t_stb)
         adr_o <= cmd_word.fields.adr;
      if (state == spi_defs_pkg::st_busy && t_stb)
         dat_o <= t_drx;                                   // only used on writes
   end

   // transmit word stays zero until the first prefetch lands
   always_ff @(posedge clk_i) begin
      if (rst_i || state == spi_defs_pkg::st_idle)
         t_dtx <= '0;
      else if (state == spi_defs_pkg::st_transfer && ack_i && !we_o)
         t_dtx <= dat_i;
   end

   // --------------------------------------------------------------------------
   //  spi target core
   // --------------------------------------------------------------------------
   spi_target target0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .sck_i      (sck_i),
      .ssel_i     (ssel_i),
      .mosi_i     (mosi_i),
      .t_dtx_i    (t_dtx),
      .miso_o     (miso_o),
      .t_cyc_o    (t_cyc),
      .t_stb_o    (t_stb),
      .t_first_o  (t_first),
      .t_drx_o    (t_drx),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o),
      .t_busy_i   (t_busy)
   );

   // classic bus rules seen from the master side
   a_stb_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o && !ack_i |=> stb_o && cyc_o);
   a_ack_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i |-> cyc_o);

endmodule

/* rtl/spi_target.sv */
`timescale 1ns/1ps

// spi mode 0 target with every pin sampled into the bus clock domain
// mosi is taken on sck rising edges and miso moves on falling edges
module spi_target (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                sck_i,      // raw pin sampled like data
   input  logic                                ssel_i,     // active low
   input  logic                                mosi_i,
   input  logic [spi_defs_pkg::frame_width-1:0] t_dtx_i,   // next byte to send
   output logic                                miso_o,
   output logic                                t_cyc_o,    // transaction open
   output logic                                t_stb_o,    // frame received
   output logic                                t_first_o,  // ... and it was the command
   output logic [spi_defs_pkg::frame_width-1:0] t_drx_o,
   output logic                                overflow_o,
   output logic                                underrun_o,
   input  logic                                t_busy_i    // bridge still on the bus
);

   // --------------------------------------------------------------------------
   //  pin synchronisers
   // --------------------------------------------------------------------------
   logic [spi_defs_pkg::sync_stages-1:0] sck_sync;
   logic [spi_defs_pkg::sync_stages-1:0] ssel_sync;
   logic [spi_defs_pkg::sync_stages-1:0] mosi_sync;
   logic                                 sck_s, ssel_s, mosi_s;
   logic                                 sck_d;          // sck_s one cycle back

   // frame tracking
   logic                                 sck_rise, sck_fall;
   logic                                 start;          // ssel just went low
   logic                                 frame_end;      // last bit sampled
   logic                                 tx_load;        // first bit of a data frame
   logic [$clog2(spi_defs_pkg::frame_width)-1:0] bit_cnt;
   logic                                 first_frame;

   // shift registers
   logic [spi_defs_pkg::frame_width-2:0] rx_sr;          // bit 0 comes from mosi_s
   logic [spi_defs_pkg::frame_width-1:0] tx_sr;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_sync  <= '0;
         ssel_sync <= '1;                      // deselected
         mosi_sync <= '0;
         sck_d     <= 1'b0;
      end else begin
         sck_sync  <= {sck_sync[spi_defs_pkg::sync_stages-2:0], sck_i};
         ssel_sync <= {ssel_sync[spi_defs_pkg::sync_stages-2:0], ssel_i};
         mosi_sync <= {mosi_sync[spi_defs_pkg::sync_stages-2:0], mosi_i};
         sck_d     <= sck_s;
      end
   end

   assign sck_s  = sck_sync[spi_defs_pkg::sync_stages-1];
   assign ssel_s = ssel_sync[spi_defs_pkg::sync_stages-1];
   assign mosi_s = mosi_sync[spi_defs_pkg::sync_stages-1];

   // --------------------------------------------------------------------------
   //  edges and frame strobes
   // --------------------------------------------------------------------------
   assign sck_rise  = sck_s & ~sck_d;
   assign sck_fall  = ~sck_s & sck_d;
   assign start     = ~ssel_s & ~t_cyc_o;
   assign frame_end = sck_rise & t_cyc_o &
                      (bit_cnt == 3'(spi_defs_pkg::frame_width - 1));
   // in mode 0 the falling edge after a full frame starts the next one
   assign tx_load   = sck_fall & t_cyc_o & (bit_cnt == '0) & ~first_frame;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         t_cyc_o     <= 1'b0;
         t_stb_o     <= 1'b0;
         t_first_o   <= 1'b0;
         bit_cnt     <= '0;
         first_frame <= 1'b0;
         overflow_o  <= 1'b0;
         underrun_o  <= 1'b0;
      end else begin
         t_cyc_o   <= ~ssel_s;
         t_stb_o   <= frame_end;                    // one cycle pulse
         t_first_o <= frame_end & first_frame;
         if (start) begin
            bit_cnt     <= '0;
            first_frame <= 1'b1;
            overflow_o  <= 1'b0;                    // flags live for one transaction
            underrun_o  <= 1'b0;
         end else if (t_cyc_o) begin
            if (sck_rise)
               bit_cnt <= bit_cnt + 1'b1;           // wraps at frame end
            if (frame_end) begin
               first_frame <= 1'b0;
               if (t_busy_i)
                  overflow_o <= 1'b1;               // previous byte not taken yet
            end
            if (tx_load && t_busy_i)
               underrun_o <= 1'b1;                  // prefetch lost the race
         end
      end
   end

   // --------------------------------------------------------------------------
   //  data path
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (sck_rise)
         rx_sr <= {rx_sr[spi_defs_pkg::frame_width-3:0], mosi_s};
      if (frame_end)
         t_drx_o <= {rx_sr, mosi_s};                // include the bit sampled now
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ssel_s)
         tx_sr <= '0;                               // miso idles low
      else if (start)
         tx_sr <= spi_defs_pkg::header_byte;        // ready before the first rise
      else if (tx_load)
         tx_sr <= t_dtx_i;
      else if (sck_fall && t_cyc_o)
         tx_sr <= {tx_sr[spi_defs_pkg::frame_width-2:0], 1'b0};
   end

   assign miso_o = tx_sr[spi_defs_pkg::frame_width-1];   // msb first

   // a strobe outside an open transaction would reach the bridge fsm
   a_stb_in_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      t_stb_o |-> t_cyc_o);

endmodule

/* rtl/bus_defs_pkg.sv */
package bus_defs_pkg;

   // --------------------------------------------------------------------------
   //  classic bus between bridge and register bank
   // --------------------------------------------------------------------------
   localparam int adr_width = 7;               // low seven bits of the command
   localparam int dat_width = 8;               // one spi frame per bus cycle

   // --------------------------------------------------------------------------
   //  register bank
   // --------------------------------------------------------------------------
   localparam int reg_count     = 16;          // eight bit registers
   localparam int reg_sel_width = 4;           // decoded address bits, rest alias

endpackage

/* rtl/spi_defs_pkg.sv */
package spi_defs_pkg;

   // --------------------------------------------------------------------------
   //  spi framing
   // --------------------------------------------------------------------------
   localparam int frame_width = 8;             // bits per frame, msb first
   localparam int sync_stages = 2;             // flops per pin synchroniser

   // shifted out on miso while the command byte comes in
   localparam logic [frame_width-1:0] header_byte = 8'hA7;

   // --------------------------------------------------------------------------
   //  bridge fsm encodings
   // --------------------------------------------------------------------------
   localparam logic [1:0] st_idle     = 2'd0;  // no transaction
   localparam logic [1:0] st_address  = 2'd1;  // waiting on the command frame
   localparam logic [1:0] st_busy     = 2'd2;  // between data frames
   localparam logic [1:0] st_transfer = 2'd3;  // bus cycle in flight

   // --------------------------------------------------------------------------
   //  command byte
   // --------------------------------------------------------------------------
   // same eight bits as received, or split into r/w flag and register address
   typedef union packed {
      logic [frame_width-1:0] raw;             // as it left the shift register
      struct packed {
         logic                   wr;           // 1 = write, 0 = read
         logic [frame_width-2:0] adr;          // fixed for the whole transaction
      } fields;
   } cmd_byte_u;

endpackage
